// File: dv/posit_alu_checker.sv
`timescale 1ns/1ps

module posit_alu_checker (
    input logic clk,
    input logic rst,
    input logic pready,
    input logic start,
    input logic res_valid,
    input logic busy,
    input logic done
);

    // No wait states on APB.
    a_pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready went low");

    // Three register stages between start and result.
    a_latency: assert property (@(posedge clk) disable iff (rst) start |-> ##3 res_valid)
        else $error("res_valid missing 3 cycles after start");

    a_no_stray_result: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> $past(start, 3))
        else $error("res_valid without start 3 cycles earlier");

    // Busy rises on the same edge as start.
    a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> !$past(busy))
        else $error("start fired while busy");

    a_done_not_busy: assert property (@(posedge clk) disable iff (rst) !(done && busy))
        else $error("done and busy both high");

endmodule

bind posit_alu_top posit_alu_checker i_checker (
    .clk       (clk),
    .rst       (rst),
    .pready    (pready),
    .start     (start),
    .res_valid (res_valid),
    .busy      (i_regs.busy),
    .done      (i_regs.done)
);

// File: dv/posit_alu_tb.sv
`timescale 1ns/1ps

module posit_alu_tb import posit_pkg::*;;

    localparam int          N        = 8;
    localparam logic [7:0]  NAR_CODE = 8'h80;
    localparam logic [7:0]  SWEEP [9] = '{8'h00, 8'h80, 8'h40, 8'hC0, 8'h01,
                                         8'h7F, 8'h23, 8'hA5, 8'hFF};

    logic        clk = 1'b0;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;

    logic [31:0] rng_state;
    int          checks;
    int          errors;

    posit_alu_top #(
        .N(N)
    ) i_dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    always #50 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model, es = 0, values scaled by 2^24.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic longint posit_mag(input logic [7:0] p);
        int     k;
        int     fb;
        int     scale;
        longint f;
        logic   r;
        r = p[6];
        k = 0;
        for (int i = 6; i >= 0; i--) begin
            if (p[i] == r && k == 6 - i) begin
                k++;  // Regime run.
            end
        end
        scale = r ? k - 1 : -k;
        fb    = (k >= 6) ? 0 : 6 - k;
        f     = longint'(p) & ((longint'(1) << fb) - 1);
        return ((longint'(1) << fb) + f) << (scale + 24 - fb);
    endfunction

    function automatic longint posit_value(input logic [7:0] p);
        logic [7:0] m;
        m = -p;
        if (p[7]) begin
            return -posit_mag(m);
        end
        return posit_mag(p);
    endfunction

    // Target is scaled by 2^48. Ties go to the even code.
    function automatic logic [7:0] nearest_posit(input longint t);
        longint     d;
        longint     best_d;
        logic [7:0] best;
        logic [7:0] c;
        best   = 8'h01;
        best_d = -1;
        for (int i = 1; i < 256; i++) begin
            c = i[7:0];
            if (c != NAR_CODE) begin
                d = (posit_value(c) <<< 24) - t;
                if (d < 0) begin
                    d = -d;
                end
                if (best_d < 0 || d < best_d || (d == best_d && !c[0])) begin
                    best   = c;
                    best_d = d;
                end
            end
        end
        return best;
    endfunction

    // Returns {unsupported, result}.
    function automatic logic [8:0] posit_ref(input logic [1:0] op,
                                             input logic [7:0] a,
                                             input logic [7:0] b);
        logic [7:0] neg_b;
        neg_b = -b;
        if (a == NAR_CODE || b == NAR_CODE) begin
            return {1'b0, NAR_CODE};
        end
        if (a == 8'h00 || b == 8'h00) begin
            case (op)
                MUL:     return 9'h000;
                ADD:     return {1'b0, (a == 8'h00) ? b : a};
                SUB:     return {1'b0, (a == 8'h00) ? neg_b : a};
                default: return {1'b0, (b == 8'h00) ? NAR_CODE : 8'h00};
            endcase
        end
        if (op != MUL) begin
            return {1'b1, NAR_CODE};
        end
        return {1'b0, nearest_posit(posit_value(a) * posit_value(b))};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_operand(output logic [7:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state[15:8];
        if (v == 8'h00 || v == NAR_CODE) begin
            v = v | 8'h01;  // Keep it ordinary.
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB access and checking.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("test failed");
        $finish;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!pready && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (!pready) begin
            stop_on_timeout("pready stayed low for 10 cycles");
        end
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        wait_ready();
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        wait_ready();
        data = prdata;  // Sampled mid-cycle.
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic wait_done(output logic [31:0] status);
        int polls;
        polls  = 0;
        status = '0;
        while (!status[STAT_DONE] && polls < 20) begin
            apb_read(ADDR_STATUS, status);
            polls++;
        end
        if (!status[STAT_DONE]) begin
            stop_on_timeout("done bit not set after 20 STATUS reads");
        end
    endtask

    task automatic start_op(input logic [1:0] op, input logic [7:0] a, input logic [7:0] b);
        apb_write(ADDR_OPA, {24'd0, a});
        apb_write(ADDR_OPB, {24'd0, b});
        apb_write(ADDR_CTRL, {30'd0, op});
    endtask

    task automatic finish_op(input string name, input logic [1:0] op,
                             input logic [7:0] a, input logic [7:0] b);
        logic [31:0] status;
        logic [31:0] result;
        logic [8:0]  expected;
        expected = posit_ref(op, a, b);
        wait_done(status);
        apb_read(ADDR_RESULT, result);
        check_value({name, " result"}, {24'd0, expected[7:0]}, result);
        check_value({name, " unsup"}, {31'd0, expected[8]}, {31'd0, status[STAT_UNSUP]});
        check_value({name, " busy"}, 32'd0, {31'd0, status[STAT_BUSY]});
    endtask

    task automatic run_op(input string name, input logic [1:0] op,
                          input logic [7:0] a, input logic [7:0] b);
        start_op(op, a, b);
        finish_op(name, op, a, b);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and comparison.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] rd;
        logic [7:0]  a;
        logic [7:0]  b;
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        rng_state = 32'd67;
        checks    = 0;
        errors    = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        apb_read(ADDR_STATUS, rd);
        check_value("reset status", 32'd0, rd);
        apb_read(ADDR_RESULT, rd);
        check_value("reset result", 32'd0, rd);

        // Zero and NaR operands on every op.
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < 9; i++) begin
                for (int j = 0; j < 9; j++) begin
                    a = SWEEP[i];
                    b = SWEEP[j];
                    if (a == 8'h00 || a == NAR_CODE || b == 8'h00 || b == NAR_CODE) begin
                        run_op($sformatf("special op%0d %h,%h", op, a, b), 2'(op), a, b);
                    end
                end
            end
        end

        // Saturation and exact ties.
        run_op("mul maxpos", MUL, 8'h7F, 8'h7F);
        run_op("mul maxpos exact", MUL, 8'h7E, 8'h60);
        run_op("mul minpos", MUL, 8'h01, 8'h01);
        run_op("mul neg minpos", MUL, 8'hFF, 8'h01);
        run_op("mul tie down", MUL, 8'h74, 8'h50);
        run_op("mul tie up", MUL, 8'h73, 8'h60);
        run_op("mul neg tie", MUL, 8'h8C, 8'h50);

        for (int n = 0; n < 200; n++) begin
            draw_operand(a);
            draw_operand(b);
            run_op($sformatf("random mul %0d %h,%h", n, a, b), MUL, a, b);
        end

        // Unsupported ops, then a MUL that clears the flag.
        for (int op = 1; op < 4; op++) begin
            run_op($sformatf("unsup op%0d", op), 2'(op), 8'h50, 8'h60);
            run_op($sformatf("unsup op%0d neg", op), 2'(op), 8'h23, 8'hA5);
        end
        run_op("mul after unsup", MUL, 8'h50, 8'h60);

        // Second CTRL write lands while busy.
        start_op(MUL, 8'h74, 8'h50);
        apb_write(ADDR_CTRL, {30'd0, DIV});
        finish_op("busy ignore", MUL, 8'h74, 8'h50);
        run_op("after busy", SUB, 8'h00, 8'h33);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module posit_alu_tb -o posit_alu_sim
./obj_dir/posit_alu_sim | tee sim.log
if grep -qx "test passed" sim.log; then
    exit 0
else
    exit 1
fi

// File: source/handle_special_or_trivial.sv
`timescale 1ns/1ps

module handle_special_or_trivial import posit_pkg::*; #(
    parameter int N = 8
) (
    input  logic [OP_SIZE-1:0] op,
    input  logic [N-1:0]       p1_in,
    input  logic [N-1:0]       p2_in,
    output logic [N-1:0]       pout
);

    localparam logic [N-1:0] ZERO = '0;
    localparam logic [N-1:0] NAR  = {1'b1, {(N-1){1'b0}}};

    // Only meaningful when one operand is zero or NaR.
    always_comb begin
        if (p1_in == NAR || p2_in == NAR) begin
            pout = NAR;
        end else begin
            case (op)
                MUL: begin
                    pout = ZERO;  // Zero times anything finite.
                end
                ADD: begin
                    pout = (p1_in == ZERO) ? p2_in : p1_in;
                end
                SUB: begin
                    // Negation is the two's complement of the word.
                    if (p1_in == ZERO) begin
                        pout = -p2_in;
                    end else begin
                        pout = p1_in;
                    end
                end
                DIV: begin
                    if (p2_in == ZERO) begin
                        pout = NAR;
                    end else begin
                        pout = ZERO;
                    end
                end
                default: begin
                    pout = NAR;
                end
            endcase
        end
    end

endmodule

// File: source/posit_alu_top.sv
`timescale 1ns/1ps

module posit_alu_top import posit_pkg::*; #(
    parameter int N = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready
);

    localparam int SW = $clog2(N) + 2;
    localparam int FW = N - 2;

    logic                 start;
    logic [OP_SIZE-1:0]   op;
    logic [N-1:0]         opa;
    logic [N-1:0]         opb;

    logic                 d_valid;
    logic [OP_SIZE-1:0]   d_op;
    logic [N-1:0]         d_opa;
    logic [N-1:0]         d_opb;
    logic                 d_special;
    logic [1:0]           d_sign;
    logic signed [SW-1:0] d_scale_a;
    logic signed [SW-1:0] d_scale_b;
    logic [FW-1:0]        d_frac_a;
    logic [FW-1:0]        d_frac_b;

    logic                 m_valid;
    logic [OP_SIZE-1:0]   m_op;
    logic [N-1:0]         m_opa;
    logic [N-1:0]         m_opb;
    logic                 m_special;
    logic                 m_sign;
    logic signed [SW-1:0] m_scale;
    logic [2*FW-1:0]      m_frac;

    logic                 res_valid;
    logic [N-1:0]         res;
    logic                 unsup;

    posit_apb_regs #(
        .N(N)
    ) i_regs (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .start     (start),
        .op        (op),
        .opa       (opa),
        .opb       (opb),
        .res_valid (res_valid),
        .res       (res),
        .unsup     (unsup)
    );

    // Stage 1.
    posit_decode_stage #(
        .N(N)
    ) i_decode (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .op        (op),
        .opa       (opa),
        .opb       (opb),
        .d_valid   (d_valid),
        .d_op      (d_op),
        .d_opa     (d_opa),
        .d_opb     (d_opb),
        .d_special (d_special),
        .d_sign    (d_sign),
        .d_scale_a (d_scale_a),
        .d_scale_b (d_scale_b),
        .d_frac_a  (d_frac_a),
        .d_frac_b  (d_frac_b)
    );

    // Stage 2.
    posit_mul_stage #(
        .N(N)
    ) i_mul (
        .clk       (clk),
        .rst       (rst),
        .d_valid   (d_valid),
        .d_op      (d_op),
        .d_opa     (d_opa),
        .d_opb     (d_opb),
        .d_special (d_special),
        .d_sign    (d_sign),
        .d_scale_a (d_scale_a),
        .d_scale_b (d_scale_b),
        .d_frac_a  (d_frac_a),
        .d_frac_b  (d_frac_b),
        .m_valid   (m_valid),
        .m_op      (m_op),
        .m_opa     (m_opa),
        .m_opb     (m_opb),
        .m_special (m_special),
        .m_sign    (m_sign),
        .m_scale   (m_scale),
        .m_frac    (m_frac)
    );

    // Stage 3.
    posit_encode_stage #(
        .N(N)
    ) i_encode (
        .clk       (clk),
        .rst       (rst),
        .m_valid   (m_valid),
        .m_op      (m_op),
        .m_opa     (m_opa),
        .m_opb     (m_opb),
        .m_special (m_special),
        .m_sign    (m_sign),
        .m_scale   (m_scale),
        .m_frac    (m_frac),
        .res_valid (res_valid),
        .res       (res),
        .unsup     (unsup)
    );

endmodule

// File: source/posit_apb_regs.sv
`timescale 1ns/1ps

module posit_apb_regs import posit_pkg::*; #(
    parameter int N = 8
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [4:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,

    output logic               start,
    output logic [OP_SIZE-1:0] op,
    output logic [N-1:0]       opa,
    output logic [N-1:0]       opb,

    input  logic               res_valid,
    input  logic [N-1:0]       res,
    input  logic               unsup
);

    logic         wr_en;
    logic         ctrl_wr;
    logic         busy;
    logic         done;
    logic         unsup_flag;
    logic [N-1:0] result_q;

    assign pready  = 1'b1;  // No wait states.
    assign wr_en   = psel && penable && pwrite;
    assign ctrl_wr = wr_en && (paddr == ADDR_CTRL);

    // Operand registers.
    always_ff @(posedge clk) begin
        if (wr_en && paddr == ADDR_OPA) begin
            opa <= pwdata[N-1:0];
        end
        if (wr_en && paddr == ADDR_OPB) begin
            opb <= pwdata[N-1:0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Start pulse, busy rule and result capture.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            start      <= 1'b0;
            op         <= MUL;
            busy       <= 1'b0;
            done       <= 1'b0;
            unsup_flag <= 1'b0;
            result_q   <= '0;
        end else begin
            start <= 1'b0;
            if (ctrl_wr && !busy) begin  // A CTRL write while busy is dropped.
                start      <= 1'b1;
                op         <= pwdata[OP_SIZE-1:0];
                busy       <= 1'b1;
                done       <= 1'b0;
                unsup_flag <= 1'b0;
            end
            if (res_valid) begin
                result_q   <= res;
                unsup_flag <= unsup;
                busy       <= 1'b0;
                done       <= 1'b1;
            end
        end
    end

    // Read mux.
    always_comb begin
        prdata = '0;
        case (paddr)
            ADDR_OPA:    prdata[N-1:0] = opa;
            ADDR_OPB:    prdata[N-1:0] = opb;
            ADDR_CTRL:   prdata[OP_SIZE-1:0] = op;
            ADDR_RESULT: prdata[N-1:0] = result_q;  // Zero-extended.
            ADDR_STATUS: begin
                prdata[STAT_BUSY]  = busy;
                prdata[STAT_DONE]  = done;
                prdata[STAT_UNSUP] = unsup_flag;
            end
            default:     prdata = '0;
        endcase
    end

endmodule

// File: source/posit_decode_stage.sv
`timescale 1ns/1ps

module posit_decode_stage import posit_pkg::*; #(
    parameter  int N  = 8,
    localparam int SW = $clog2(N) + 2,
    localparam int FW = N - 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic [OP_SIZE-1:0]  op,
    input  logic [N-1:0]        opa,
    input  logic [N-1:0]        opb,

    output logic                d_valid,
    output logic [OP_SIZE-1:0]  d_op,
    output logic [N-1:0]        d_opa,
    output logic [N-1:0]        d_opb,
    output logic                d_special,
    output logic [1:0]          d_sign,     // {sign a, sign b}.
    output logic signed [SW-1:0] d_scale_a,
    output logic signed [SW-1:0] d_scale_b,
    output logic [FW-1:0]       d_frac_a,   // Hidden bit at the top.
    output logic [FW-1:0]       d_frac_b
);

    localparam logic [N-1:0] ZERO = '0;
    localparam logic [N-1:0] NAR  = {1'b1, {(N-1){1'b0}}};

    logic [SW-1:0] scale_a;
    logic [SW-1:0] scale_b;
    logic [FW-1:0] frac_a;
    logic [FW-1:0] frac_b;
    logic          special;

    // Splits a posit into scale and fraction, es = 0.
    function automatic logic [SW+FW-1:0] unpack(input logic [N-1:0] p);
        logic [N-1:0]  mag;
        logic [N-2:0]  body;
        logic [SW-1:0] run;
        logic [SW-1:0] scale;
        logic          stop;
        mag  = p[N-1] ? -p : p;
        run  = '0;
        stop = 1'b0;
        for (int i = N - 2; i >= 0; i--) begin
            if (!stop && mag[i] == mag[N-2]) begin
                run = run + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
        scale = mag[N-2] ? run - 1'b1 : -run;
        body  = mag[N-2:0] << (run + 1'b1);  // Drop regime and terminator.
        return {scale, 1'b1, body[N-2 -: FW-1]};
    endfunction

    assign {scale_a, frac_a} = unpack(opa);
    assign {scale_b, frac_b} = unpack(opb);

    assign special = (opa == ZERO) || (opa == NAR) || (opb == ZERO) || (opb == NAR);

    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        d_op      <= op;
        d_opa     <= opa;
        d_opb     <= opb;
        d_special <= special;
        d_sign    <= {opa[N-1], opb[N-1]};
        d_scale_a <= scale_a;
        d_scale_b <= scale_b;
        d_frac_a  <= frac_a;
        d_frac_b  <= frac_b;
    end

endmodule

// File: source/posit_encode_stage.sv
`timescale 1ns/1ps

module posit_encode_stage import posit_pkg::*; #(
    parameter  int N  = 8,
    localparam int SW = $clog2(N) + 2,
    localparam int FW = N - 2
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 m_valid,
    input  logic [OP_SIZE-1:0]   m_op,
    input  logic [N-1:0]         m_opa,
    input  logic [N-1:0]         m_opb,
    input  logic                 m_special,
    input  logic                 m_sign,
    input  logic signed [SW-1:0] m_scale,
    input  logic [2*FW-1:0]      m_frac,

    output logic                 res_valid,
    output logic [N-1:0]         res,
    output logic                 unsup
);

    localparam logic [N-1:0] NAR  = {1'b1, {(N-1){1'b0}}};
    localparam int           MAXS = N - 2;
    localparam int           EW   = 2 * FW + N - 1;

    logic [N-1:0]  pout;
    logic [SW-1:0] sh;
    logic [EW-1:0] seed;
    logic [EW-1:0] ext;
    logic [N-2:0]  top;
    logic          guard;
    logic          sticky;
    logic          round_up;
    logic [N-2:0]  mag;
    logic [N-1:0]  mul_res;

    handle_special_or_trivial #(
        .N(N)
    ) i_special (
        .op    (m_op),
        .p1_in (m_opa),
        .p2_in (m_opb),
        .pout  (pout)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Regime and fraction build, then round to nearest even.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        sh   = m_scale[SW-1] ? ~m_scale : m_scale;  // -s-1 or s.
        seed = {(m_scale[SW-1] ? 2'b01 : 2'b10), m_frac[2*FW-2:0], {(N-2){1'b0}}};
        if (m_scale[SW-1]) begin
            ext = seed >> sh;       // Run of zeros, then a one.
        end else begin
            ext = ~((~seed) >> sh); // Run of ones, then a zero.
        end
        top      = ext[EW-1 -: N-1];
        guard    = ext[EW-N];
        sticky   = |ext[EW-N-1:0];
        round_up = guard && (sticky || top[0]);
        if (m_scale > MAXS) begin
            mag = '1;                   // Maxpos.
        end else if (m_scale < -MAXS) begin
            mag = {{(N-2){1'b0}}, 1'b1}; // Minpos.
        end else begin
            mag = top + round_up;
        end
        mul_res = m_sign ? -{1'b0, mag} : {1'b0, mag};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
            unsup     <= 1'b0;
        end else begin
            res_valid <= m_valid;
            unsup     <= m_valid && !m_special && (m_op != MUL);
        end
    end

    always_ff @(posedge clk) begin
        if (m_special) begin
            res <= pout;
        end else if (m_op == MUL) begin
            res <= mul_res;
        end else begin
            res <= NAR;  // ADD, SUB and DIV of ordinary values.
        end
    end

endmodule

// File: source/posit_mul_stage.sv
`timescale 1ns/1ps

module posit_mul_stage import posit_pkg::*; #(
    parameter  int N  = 8,
    localparam int SW = $clog2(N) + 2,
    localparam int FW = N - 2
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 d_valid,
    input  logic [OP_SIZE-1:0]   d_op,
    input  logic [N-1:0]         d_opa,
    input  logic [N-1:0]         d_opb,
    input  logic                 d_special,
    input  logic [1:0]           d_sign,
    input  logic signed [SW-1:0] d_scale_a,
    input  logic signed [SW-1:0] d_scale_b,
    input  logic [FW-1:0]        d_frac_a,
    input  logic [FW-1:0]        d_frac_b,

    output logic                 m_valid,
    output logic [OP_SIZE-1:0]   m_op,
    output logic [N-1:0]         m_opa,
    output logic [N-1:0]         m_opb,
    output logic                 m_special,
    output logic                 m_sign,
    output logic signed [SW-1:0] m_scale,
    output logic [2*FW-1:0]      m_frac    // Normalized, hidden bit at the top.
);

    logic [2*FW-1:0]      prod;
    logic signed [SW-1:0] scale_sum;
    logic                 ovf;

    assign prod      = d_frac_a * d_frac_b;  // Value in [1, 4).
    assign ovf       = prod[2*FW-1];
    assign scale_sum = d_scale_a + d_scale_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else begin
            m_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        m_op      <= d_op;
        m_opa     <= d_opa;
        m_opb     <= d_opb;
        m_special <= d_special;
        m_sign    <= d_sign[1] ^ d_sign[0];
        if (ovf) begin
            m_scale <= scale_sum + 1'b1;  // Product is two or more.
            m_frac  <= prod;
        end else begin
            m_scale <= scale_sum;
            m_frac  <= prod << 1;
        end
    end

endmodule

// File: source/posit_pkg.sv
package posit_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operation codes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int OP_SIZE = 2;

    localparam logic [OP_SIZE-1:0] MUL = 2'd0;
    localparam logic [OP_SIZE-1:0] ADD = 2'd1;
    localparam logic [OP_SIZE-1:0] SUB = 2'd2;
    localparam logic [OP_SIZE-1:0] DIV = 2'd3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB register map.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [4:0] ADDR_OPA    = 5'h00;
    localparam logic [4:0] ADDR_OPB    = 5'h04;
    localparam logic [4:0] ADDR_CTRL   = 5'h08;  // Op code in bits 1:0.
    localparam logic [4:0] ADDR_RESULT = 5'h0C;
    localparam logic [4:0] ADDR_STATUS = 5'h10;

    // Bit positions in the STATUS word.
    localparam int STAT_BUSY  = 0;
    localparam int STAT_DONE  = 1;
    localparam int STAT_UNSUP = 2;

endpackage

// File: sources.f
source/posit_pkg.sv
source/handle_special_or_trivial.sv
source/posit_apb_regs.sv
source/posit_decode_stage.sv
source/posit_mul_stage.sv
source/posit_encode_stage.sv
source/posit_alu_top.sv
dv/posit_alu_checker.sv
dv/posit_alu_tb.sv
